// File: list.f
+incdir+source
source/bp_pkg.sv
source/bp_update_if.sv
source/bimodal_table.sv
source/gshare_table.sv
source/tournament_chooser.sv
source/branch_predictor.sv
tb/bp_checker.sv
tb/tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - include_dirs:
      - source
    files:
      - source/bp_pkg.sv
      - source/bp_update_if.sv
      - source/bimodal_table.sv
      - source/gshare_table.sv
      - source/tournament_chooser.sv
      - source/branch_predictor.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/bp_checker.sv
      - tb/tb_branch_predictor.sv

// File: tb/tb_branch_predictor.sv
// tournament branch predictor testbench
// drives a table of named rows and a pseudo-random tail into the DUT,
// a separate checker module models the tables and compares

`timescale 1ns/1ns

`include "bp_config.svh"

module tb_branch_predictor import bp_pkg::*; ();

  localparam int          TABLE_ROWS     = 35;
  localparam int          RANDOM_ROWS    = 200;
  localparam int          TOTAL_TESTS    = TABLE_ROWS + RANDOM_ROWS;
  localparam int          TIMEOUT_CYCLES = 50;       // per wait loop
  localparam logic [15:0] LFSR_SEED      = 16'd18554;
  localparam int          NAME_BITS      = 8 * 16;   // 16 ascii chars

  logic                 clock;
  logic                 rst_n;
  logic                 stall;
  bp_idx_t              inst_addr;
  logic                 update;
  bp_idx_t              buffer_addr;
  bp_slot_t             buffer_offset;
  logic                 branch_result;
  bp_pred_t             prediction;
  logic [NAME_BITS-1:0] test_name; // row being applied
  logic                 active;    // row under test this cycle
  int                   pass_count;
  int                   fail_count;

  // stimulus table, one entry per fetch cycle
  logic                 t_stall  [TABLE_ROWS];
  bp_idx_t              t_addr   [TABLE_ROWS];
  logic                 t_update [TABLE_ROWS];
  bp_idx_t              t_baddr  [TABLE_ROWS];
  bp_slot_t             t_boff   [TABLE_ROWS];
  logic                 t_result [TABLE_ROWS];
  logic [NAME_BITS-1:0] t_name   [TABLE_ROWS];
  int                   fill;      // next free table row
  logic [15:0]          lfsr;      // random tail state

  branch_predictor branch_predictor_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .stall         (stall),
    .inst_addr     (inst_addr),
    .update        (update),
    .buffer_addr   (buffer_addr),
    .buffer_offset (buffer_offset),
    .branch_result (branch_result),
    .prediction    (prediction)
  );

  bp_checker checker_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .stall         (stall),
    .inst_addr     (inst_addr),
    .update        (update),
    .buffer_addr   (buffer_addr),
    .buffer_offset (buffer_offset),
    .branch_result (branch_result),
    .prediction    (prediction),
    .test_name     (test_name),
    .active        (active),
    .pass_count    (pass_count),
    .fail_count    (fail_count)
  );

  initial clock = 1'b0;
  always #10 clock = ~clock; // 20 ns period

  // reset held for ten rising edges
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clock);
    #2 rst_n = 1'b1;
  end

  // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken, lsb first
  task automatic take_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // append n identical rows to the table
  task automatic add_rows(input int n, input logic s, input bp_idx_t a, input logic u,
                          input bp_idx_t ba, input bp_slot_t bo, input logic r,
                          input logic [NAME_BITS-1:0] nm);
    for (int i = 0; i < n; i++) begin
      t_stall[fill]  = s;
      t_addr[fill]   = a;
      t_update[fill] = u;
      t_baddr[fill]  = ba;
      t_boff[fill]   = bo;
      t_result[fill] = r;
      t_name[fill]   = nm;
      fill++;
    end
  endtask

  task automatic build_table();
    add_rows(1, 0, 2'd0, 0, 2'd0, 2'd0, 0, "reset_lookup");
    add_rows(2, 0, 2'd0, 1, 2'd1, 2'd2, 1, "b1_train");     // slot 2 of entry 1
    add_rows(1, 0, 2'd1, 0, 2'd0, 2'd0, 0, "b1_flip");
    add_rows(5, 0, 2'd2, 1, 2'd2, 2'd0, 1, "sat_up");       // pinned at strong taken
    add_rows(1, 0, 2'd2, 1, 2'd2, 2'd0, 0, "sat_down");
    add_rows(1, 0, 2'd2, 0, 2'd0, 2'd0, 0, "sat_check");
    add_rows(3, 0, 2'd3, 1, 2'd3, 2'd1, 0, "snt_down");     // pinned at strong not taken
    add_rows(1, 0, 2'd3, 1, 2'd3, 2'd1, 1, "snt_up");
    add_rows(1, 0, 2'd3, 0, 2'd0, 2'd0, 0, "snt_check");
    add_rows(2, 1, 2'd1, 1, 2'd0, 2'd3, 1, "stall_hold");   // training under stall
    add_rows(1, 1, 2'd3, 1, 2'd0, 2'd3, 1, "stall_hold");
    add_rows(1, 0, 2'd0, 0, 2'd0, 2'd0, 0, "stall_release");
    for (int k = 0; k < 4; k++) begin
      add_rows(1, 0, 2'd0, 1, 2'd0, 2'd1, 1, "hist_alt");   // taken
      add_rows(1, 0, 2'd0, 1, 2'd0, 2'd1, 0, "hist_alt");   // then not taken
    end
    for (int k = 0; k < 4; k++) begin
      add_rows(1, 0, bp_idx_t'(k), 0, 2'd0, 2'd0, 0, "hist_check");
    end
    add_rows(2, 0, 2'd3, 1, 2'd3, 2'd3, 1, "same_cycle");   // lookup and update together
    add_rows(1, 0, 2'd3, 0, 2'd0, 2'd0, 0, "same_check");
  endtask

  // one row per cycle, 2 ns after the rising edge
  task automatic apply_row(input logic s, input bp_idx_t a, input logic u, input bp_idx_t ba,
                           input bp_slot_t bo, input logic r,
                           input logic [NAME_BITS-1:0] nm);
    @(posedge clock);
    #2;
    stall         = s;
    inst_addr     = a;
    update        = u;
    buffer_addr   = ba;
    buffer_offset = bo;
    branch_result = r;
    test_name     = nm;
    active        = 1'b1;
  endtask

  initial begin
    int         waited;
    logic [3:0] bits_s;
    logic [3:0] bits_a;
    logic [3:0] bits_u;
    logic [3:0] bits_ba;
    logic [3:0] bits_bo;
    logic [3:0] bits_r;
    stall         = 1'b0;
    inst_addr     = '0;
    update        = 1'b0;
    buffer_addr   = '0;
    buffer_offset = '0;
    branch_result = 1'b0;
    test_name     = '0;
    active        = 1'b0;
    lfsr          = LFSR_SEED;
    fill          = 0;
    build_table();
    waited = 0;
    while (rst_n !== 1'b1 && waited < TIMEOUT_CYCLES) begin
      @(posedge clock);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      $display("test failed");
    end else begin
      for (int r = 0; r < TABLE_ROWS; r++) begin
        apply_row(t_stall[r], t_addr[r], t_update[r], t_baddr[r], t_boff[r], t_result[r],
                  t_name[r]);
      end
      // random tail, stall about one cycle in four
      for (int r = 0; r < RANDOM_ROWS; r++) begin
        take_bits(2, bits_s);
        take_bits(2, bits_a);
        take_bits(1, bits_u);
        take_bits(2, bits_ba);
        take_bits(2, bits_bo);
        take_bits(1, bits_r);
        apply_row(&bits_s[1:0], bits_a[1:0], bits_u[0], bits_ba[1:0], bits_bo[1:0],
                  bits_r[0], "random");
      end
      @(posedge clock);
      #2;
      active = 1'b0;
      update = 1'b0;
      waited = 0;
      while ((pass_count + fail_count) < TOTAL_TESTS && waited < TIMEOUT_CYCLES) begin
        @(posedge clock);
        waited++;
      end
      $display("checks passed %0d failed %0d", pass_count, fail_count);
      if ((pass_count + fail_count) < TOTAL_TESTS) begin
        $display("checker finished only %0d of %0d tests", pass_count + fail_count,
                 TOTAL_TESTS);
        $display("test failed");
      end else if (fail_count != 0) begin
        $display("test failed");
      end else begin
        $display("test passed");
      end
    end
    $finish;
  end

endmodule

// File: tb/bp_checker.sv
// branch predictor checker
// independent model of the bimodal, global and chooser tables,
// compares the DUT prediction after every applied row

`timescale 1ns/1ns

`include "bp_config.svh"

module bp_checker import bp_pkg::*; (
  input  logic           clock,
  input  logic           rst_n,
  input  logic           stall,
  input  bp_idx_t        inst_addr,
  input  logic           update,
  input  bp_idx_t        buffer_addr,
  input  bp_slot_t       buffer_offset,
  input  logic           branch_result,
  input  bp_pred_t       prediction,
  input  logic [127:0]   test_name,  // ascii row name
  input  logic           active,     // row present this cycle
  output int             pass_count,
  output int             fail_count
);

  localparam int ENTRIES   = 1 << `BP_INDEX_BITS;
  localparam int HIST_MASK = (1 << `BP_HIST_BITS) - 1;

  int           bim [`BP_SLOTS][ENTRIES]; // 0..3 counters
  int           gsh [`BP_SLOTS][ENTRIES];
  int           sel [`BP_SLOTS][ENTRIES]; // >= 2 means global
  int           hist;
  int           gidx;                     // hashed update index
  logic         bbit;
  logic         gbit;
  bp_pred_t     bim_q;                    // model lookup registers
  bp_pred_t     gsh_q;
  bp_pred_t     sel_q;
  bp_pred_t     expected;
  logic [127:0] cur_name;                 // row sampled at last edge
  logic         cur_active;

  // 2-bit saturating counter rule
  function automatic int sat_step(input int v, input logic taken);
    if (taken) begin
      return (v == 3) ? 3 : v + 1;
    end
    return (v == 0) ? 0 : v - 1;
  endfunction

  initial begin
    pass_count = 0;
    fail_count = 0;
  end

  // model state, lookups first so they see pre-update counters
  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        for (int e = 0; e < ENTRIES; e++) begin
          bim[s][e] = 1; // weak not taken
          gsh[s][e] = 1;
          sel[s][e] = 1; // weakly bimodal
        end
      end
      hist       = 0;
      bim_q      = '0;
      gsh_q      = '0;
      sel_q      = '0;
      cur_active = 1'b0;
      cur_name   = '0;
    end else begin
      cur_name   = test_name;
      cur_active = active;
      if (!stall) begin
        for (int s = 0; s < `BP_SLOTS; s++) begin
          bim_q[s] = (bim[s][inst_addr] >= 2);
          gsh_q[s] = (gsh[s][inst_addr ^ hist] >= 2); // old history
          sel_q[s] = (sel[s][inst_addr] >= 2);
        end
      end
      if (update) begin
        gidx = buffer_addr ^ hist;
        bbit = (bim[buffer_offset][buffer_addr] >= 2);
        gbit = (gsh[buffer_offset][gidx] >= 2);
        bim[buffer_offset][buffer_addr] = sat_step(bim[buffer_offset][buffer_addr],
                                                   branch_result);
        gsh[buffer_offset][gidx] = sat_step(gsh[buffer_offset][gidx], branch_result);
        if (bbit != gbit) begin // chooser learns on disagreement only
          sel[buffer_offset][buffer_addr] = sat_step(sel[buffer_offset][buffer_addr],
                                                     gbit == branch_result);
        end
        hist = ((hist << 1) | branch_result) & HIST_MASK; // newest at lsb
      end
    end
  end

  // DUT output settled by the falling edge
  always @(negedge clock) begin
    if (rst_n && cur_active) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        if (sel_q[s]) begin
          expected[s] = gsh_q[s];
        end else begin
          expected[s] = bim_q[s];
        end
      end
      if (prediction !== expected) begin
        $display("[ERROR] %0s expected %b actual %b", cur_name, expected, prediction);
        fail_count++;
      end else begin
        $display("ok %0s prediction %b select %b", cur_name, prediction, sel_q);
        pass_count++;
      end
      cur_active = 1'b0; // one result per row
    end
  end

endmodule

// File: source/branch_predictor.sv
// tournament branch predictor top
// bimodal and global-history tables side by side, a chooser picking
// per slot between them, one resolved-branch update per cycle

`timescale 1ns/1ns

module branch_predictor import bp_pkg::*; (
  input  logic     clock,
  input  logic     rst_n,
  input  logic     stall,         // no new fetch group this cycle
  input  bp_idx_t  inst_addr,     // fetch group index
  input  logic     update,        // resolved branch strobe
  input  bp_idx_t  buffer_addr,   // resolved entry
  input  bp_slot_t buffer_offset, // resolved slot
  input  logic     branch_result, // 1 = taken
  output bp_pred_t prediction     // per-slot taken bits, one cycle later
);

  bp_pred_t bim_pred;     // bimodal lookup
  bp_pred_t gsh_pred;     // global lookup
  logic     bim_upd_pred; // bimodal view of the updated entry
  logic     gsh_upd_pred; // global view of the updated entry

  // update bus fed straight from the ports
  bp_update_if upd_bus ();

  assign upd_bus.update        = update;
  assign upd_bus.buffer_addr   = buffer_addr;
  assign upd_bus.buffer_offset = buffer_offset;
  assign upd_bus.branch_result = branch_result;

  bimodal_table bimodal_table_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .stall     (stall),
    .inst_addr (inst_addr),
    .upd       (upd_bus),
    .slot_pred (bim_pred),
    .upd_pred  (bim_upd_pred)
  );

  gshare_table gshare_table_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .stall     (stall),
    .inst_addr (inst_addr),
    .upd       (upd_bus),
    .slot_pred (gsh_pred),
    .upd_pred  (gsh_upd_pred)
  );

  tournament_chooser tournament_chooser_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .stall        (stall),
    .inst_addr    (inst_addr),
    .upd          (upd_bus),
    .bim_pred     (bim_pred),
    .gsh_pred     (gsh_pred),
    .bim_upd_pred (bim_upd_pred),
    .gsh_upd_pred (gsh_upd_pred),
    .prediction   (prediction)
  );

endmodule

// File: source/tournament_chooser.sv
// tournament chooser
// per-entry, per-slot selector counters trained when the two component
// predictors disagree
// msb set selects the global prediction

`timescale 1ns/1ns

`include "bp_config.svh"

module tournament_chooser import bp_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       stall,        // hold select register
  input  bp_idx_t    inst_addr,    // fetch group index
  bp_update_if.sink  upd,          // resolved branch
  input  bp_pred_t   bim_pred,     // registered bimodal lookup
  input  bp_pred_t   gsh_pred,     // registered global lookup
  input  logic       bim_upd_pred, // bimodal bit of the updated entry
  input  logic       gsh_upd_pred, // global bit of the updated entry
  output bp_pred_t   prediction    // to the decoder
);

  localparam int ENTRIES = 1 << `BP_INDEX_BITS;

  // selector counters that prefer global in their upper half
  ctr_state_e sel_ctr [`BP_SLOTS][ENTRIES];
  bp_pred_t   sel_q;     // registered per-slot select
  logic       disagree;  // components differ on the updated entry
  logic       gsh_right; // global matched the outcome

  assign disagree  = bim_upd_pred ^ gsh_upd_pred;
  assign gsh_right = (gsh_upd_pred == upd.branch_result);

  // train only when one component was right and the other wrong
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        for (int e = 0; e < ENTRIES; e++) begin
          sel_ctr[s][e] <= CTR_WNT; // weakly prefer bimodal
        end
      end
    end else if (upd.update && disagree) begin
      sel_ctr[upd.buffer_offset][upd.buffer_addr] <=
        ctr_next(sel_ctr[upd.buffer_offset][upd.buffer_addr], gsh_right);
    end
  end

  // select register aligned with the component lookup registers
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
    end else if (!stall) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        sel_q[s] <= sel_ctr[s][inst_addr][1]; // 1 = take global
      end
    end
  end

  // per-slot mux of the two registered component predictions
  assign prediction = (sel_q & gsh_pred) | (~sel_q & bim_pred);

  // select follows the same stall contract as the tables
  a_sel_stall_holds: assert property (
    @(posedge clock) disable iff (!rst_n)
    stall |=> $stable(sel_q)
  ) else $error("chooser select changed under stall");

endmodule

// File: source/gshare_table.sv
// global history predictor
// shift register of recent branch outcomes, xor-hashed with the fetch
// index into per-slot banks of 2-bit saturating counters

`timescale 1ns/1ns

`include "bp_config.svh"

module gshare_table import bp_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       stall,     // hold lookup register
  input  bp_idx_t    inst_addr, // fetch group index
  bp_update_if.sink  upd,       // resolved branch
  output bp_pred_t   slot_pred, // registered taken bits
  output logic       upd_pred   // current bit of the hashed update entry
);

  localparam int ENTRIES = 1 << `BP_INDEX_BITS;

  ctr_state_e ctr [`BP_SLOTS][ENTRIES]; // counter banks per slot
  bp_hist_t   hist;                     // newest outcome at lsb
  bp_idx_t    lookup_idx;               // hashed fetch index
  bp_idx_t    update_idx;               // hashed update index

  // history zero-extended into the index width
  assign lookup_idx = inst_addr ^ bp_idx_t'(hist);
  assign update_idx = upd.buffer_addr ^ bp_idx_t'(hist);

  // history shift, one step per resolved branch
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      hist <= '0;
    end else if (upd.update) begin
      hist <= bp_hist_t'({hist, upd.branch_result}); // oldest bit drops off
    end
  end

  // counter training with the pre-shift history
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        for (int e = 0; e < ENTRIES; e++) begin
          ctr[s][e] <= CTR_WNT;
        end
      end
    end else if (upd.update) begin
      ctr[upd.buffer_offset][update_idx] <=
        ctr_next(ctr[upd.buffer_offset][update_idx], upd.branch_result);
    end
  end

  // lookup register, old history and old counters
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      slot_pred <= '0;
    end else if (!stall) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        slot_pred[s] <= ctr[s][lookup_idx][1];
      end
    end
  end

  // this table's opinion on the entry the update trains
  assign upd_pred = ctr[upd.buffer_offset][update_idx][1];

  // history only moves on a resolved branch
  a_hist_needs_update: assert property (
    @(posedge clock) disable iff (!rst_n)
    !upd.update |=> $stable(hist)
  ) else $error("global history changed without an update");

  // same stall contract as the bimodal side
  a_stall_holds: assert property (
    @(posedge clock) disable iff (!rst_n)
    stall |=> $stable(slot_pred)
  ) else $error("global prediction changed under stall");

endmodule

// File: source/bimodal_table.sv
// bimodal predictor
// one bank of 2-bit saturating counters per fetch slot, indexed by the
// fetch address; taken bits are registered on unstalled cycles

`timescale 1ns/1ns

`include "bp_config.svh"

module bimodal_table import bp_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       stall,     // hold lookup register
  input  bp_idx_t    inst_addr, // fetch group index
  bp_update_if.sink  upd,       // resolved branch
  output bp_pred_t   slot_pred, // registered taken bits
  output logic       upd_pred   // current bit of the entry being updated
);

  localparam int ENTRIES = 1 << `BP_INDEX_BITS;

  // counter banks, first dimension is the slot
  ctr_state_e ctr [`BP_SLOTS][ENTRIES];

  // counter training
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        for (int e = 0; e < ENTRIES; e++) begin
          ctr[s][e] <= CTR_WNT; // everything starts weak not taken
        end
      end
    end else if (upd.update) begin
      // single entry per cycle, bank picked by slot
      ctr[upd.buffer_offset][upd.buffer_addr] <=
        ctr_next(ctr[upd.buffer_offset][upd.buffer_addr], upd.branch_result);
    end
  end

  // lookup register, sees counters before this edge's update
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      slot_pred <= '0;
    end else if (!stall) begin
      for (int s = 0; s < `BP_SLOTS; s++) begin
        slot_pred[s] <= ctr[s][inst_addr][1]; // msb = taken
      end
    end
  end

  // chooser training needs this table's opinion on the updated entry
  assign upd_pred = ctr[upd.buffer_offset][upd.buffer_addr][1];

  // strong taken can only fall to weak taken, still taken next cycle
  for (genvar gs = 0; gs < `BP_SLOTS; gs++) begin : g_sat_slot
    for (genvar ge = 0; ge < ENTRIES; ge++) begin : g_sat_entry
      a_strong_taken_sticks: assert property (
        @(posedge clock) disable iff (!rst_n)
        (ctr[gs][ge] == CTR_ST) |=> ctr[gs][ge][1]
      ) else $error("bimodal counter left taken from strong taken");
    end
  end

  // a stalled fetch keeps its prediction
  a_stall_holds: assert property (
    @(posedge clock) disable iff (!rst_n)
    stall |=> $stable(slot_pred)
  ) else $error("bimodal prediction changed under stall");

endmodule

// File: source/bp_update_if.sv
// resolved branch update bus
// one branch outcome per cycle, broadcast to the bimodal table,
// the global table and the chooser; no handshake, update is a strobe

`timescale 1ns/1ns

interface bp_update_if import bp_pkg::*; ();

  logic     update;        // one cycle per resolved branch
  bp_idx_t  buffer_addr;   // entry of the resolved branch
  bp_slot_t buffer_offset; // slot bank of the resolved branch
  logic     branch_result; // 1 = taken

  // driving side, fetch/resolve logic at the top
  modport source (
    output update,
    output buffer_addr,
    output buffer_offset,
    output branch_result
  );

  // receiving side, every table
  modport sink (
    input update,
    input buffer_addr,
    input buffer_offset,
    input branch_result
  );

endinterface

// File: source/bp_pkg.sv
// branch predictor types
// counter encoding, index, slot, prediction and history types,
// plus the saturating counter step shared by all three tables

`include "bp_config.svh"

package bp_pkg;

  // 2-bit saturating counter, msb is the taken prediction
  typedef enum logic [1:0] {
    CTR_SNT = 2'd0, // strong not taken
    CTR_WNT = 2'd1, // weak not taken, reset value
    CTR_WT  = 2'd2, // weak taken
    CTR_ST  = 2'd3  // strong taken
  } ctr_state_e;

  typedef logic [`BP_INDEX_BITS-1:0] bp_idx_t;  // table entry
  typedef logic [1:0]                bp_slot_t; // slot within fetch group
  typedef logic [`BP_SLOTS-1:0]      bp_pred_t; // one taken bit per slot
  typedef logic [`BP_HIST_BITS-1:0]  bp_hist_t; // global history

  // one step up or down, saturating at both ends
  function automatic ctr_state_e ctr_next(input ctr_state_e cur, input logic up);
    ctr_state_e nxt;
    nxt = cur;
    if (up && (cur != CTR_ST)) begin
      nxt = ctr_state_e'(cur + 2'd1); // toward strong taken
    end else if (!up && (cur != CTR_SNT)) begin
      nxt = ctr_state_e'(cur - 2'd1); // toward strong not taken
    end
    return nxt;
  endfunction

endpackage

// File: source/bp_config.svh
// branch predictor configuration
// sizes of the counter tables, the fetch group and the global history
// shared by the package and every predictor block

`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// index width of every table, four entries per bank
`define BP_INDEX_BITS 2

// instruction slots per fetch group, one counter bank each
`define BP_SLOTS 4

// global taken/not-taken history length
// kept at or below BP_INDEX_BITS so the hash stays inside the index
`define BP_HIST_BITS 2

`endif
